//--- src/csr_macros.svh
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

`define CSR_NUM_WARPS    4
`define CSR_NUM_THREADS  2
`define CSR_NW_BITS      2      // warp id width.
`define CSR_NT_BITS      1      // lane index width.
`define CSR_XLEN         32
`define CSR_ADDR_BITS    12
`define CSR_UUID_BITS    8
`define CSR_NR_BITS      5
`define CSR_IMM_BITS     5

`define CSR_NUM_SCRATCH  4
`define CSR_SCRATCH_BITS 2

`define CSR_SCRATCH0     12'h7C0
`define CSR_SCRATCH1     12'h7C1
`define CSR_SCRATCH2     12'h7C2
`define CSR_SCRATCH3     12'h7C3
`define CSR_THREAD_ID    12'hCC0
`define CSR_WARP_ID      12'hCC1
`define CSR_CORE_ID      12'hCC2

`endif

//--- src/csr_pkg.sv
`default_nettype none

`include "csr_macros.svh"

package csr_pkg;

    // encodings follow the funct3 low bits of the csr instructions.
    typedef enum logic [1:0] {
        CSR_RW = 2'd1,
        CSR_RS = 2'd2,
        CSR_RC = 2'd3
    } csr_op_e;

    typedef struct packed {
        logic [`CSR_UUID_BITS-1:0]                      uuid;
        logic [`CSR_NW_BITS-1:0]                        wid;
        logic [`CSR_NUM_THREADS-1:0]                    tmask;
        logic [31:0]                                    pc;
        logic [`CSR_NR_BITS-1:0]                        rd;
        logic                                           wb;
        csr_op_e                                        op;
        logic                                           use_imm;
        logic [`CSR_IMM_BITS-1:0]                       imm;
        logic [`CSR_ADDR_BITS-1:0]                      addr;
        logic [`CSR_NT_BITS-1:0]                        tid;
        logic [`CSR_NUM_THREADS-1:0][`CSR_XLEN-1:0]     rs1_data;
    } csr_req_t;

    typedef struct packed {
        logic [`CSR_UUID_BITS-1:0]                      uuid;
        logic [`CSR_NW_BITS-1:0]                        wid;
        logic [`CSR_NUM_THREADS-1:0]                    tmask;
        logic [31:0]                                    pc;
        logic [`CSR_NR_BITS-1:0]                        rd;
        logic                                           wb;
        logic                                           eop;
        logic [`CSR_NUM_THREADS-1:0][`CSR_XLEN-1:0]     data;
    } csr_rsp_t;

    typedef struct packed {
        logic [`CSR_NW_BITS-1:0]                        wid;
        logic [`CSR_ADDR_BITS-1:0]                      addr;
        logic [`CSR_NT_BITS-1:0]                        tid;    // lane whose value is stored.
        logic                                           we;
        logic [`CSR_NUM_THREADS-1:0][`CSR_XLEN-1:0]     data;
    } csr_wr_t;

endpackage

`default_nettype wire

//--- src/csr_skid_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module csr_skid_buffer #(
    parameter int DATAW = 8
) (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             valid_in,
    output logic                  ready_in,
    input  wire logic [DATAW-1:0] data_in,
    output logic      [DATAW-1:0] data_out,
    output logic                  valid_out,
    input  wire logic             ready_out
);

    logic [DATAW-1:0] main_data;
    logic [DATAW-1:0] skid_data;
    logic             main_valid;
    logic             skid_valid;
    logic             push;
    logic             pop;

    assign ready_in = ~skid_valid;      // registered state only.
    assign push     = valid_in && ready_in;
    assign pop      = main_valid && ready_out;

    always_ff @(posedge clk) begin
        if (reset) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (skid_valid) begin
            if (pop) begin
                skid_valid <= 1'b0;     // skid entry moves up and main stays valid.
            end
        end else if (push) begin
            if (!main_valid || pop) begin
                main_valid <= 1'b1;
            end else begin
                skid_valid <= 1'b1;
            end
        end else if (pop) begin
            main_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (skid_valid) begin
            if (pop) main_data <= skid_data;
        end else if (push) begin
            if (!main_valid || pop) begin
                main_data <= data_in;
            end else begin
                skid_data <= data_in;   // parked while the output is stalled.
            end
        end
    end

    assign data_out  = main_data;
    assign valid_out = main_valid;

endmodule

`default_nettype wire

//--- src/csr_data.sv
`timescale 1ns/10ps
`default_nettype none

`include "csr_macros.svh"

module csr_data #(
    parameter int CORE_ID = 0
) (
    input  wire logic                                          clk,
    input  wire logic                                          reset,
    input  wire logic [`CSR_NW_BITS-1:0]                       read_wid,
    input  wire logic [`CSR_ADDR_BITS-1:0]                     read_addr,
    output logic      [`CSR_NUM_THREADS-1:0][`CSR_XLEN-1:0]    read_data,
    input  wire csr_pkg::csr_wr_t                              write,
    input  wire logic                                          write_enable
);

    // per-warp scratch words.
    logic [`CSR_NUM_WARPS-1:0][`CSR_NUM_SCRATCH-1:0][`CSR_XLEN-1:0] scratch;

    logic [`CSR_ADDR_BITS-1:0]    read_off;
    logic [`CSR_ADDR_BITS-1:0]    write_off;
    logic                         read_hit;
    logic                         write_hit;
    logic [`CSR_SCRATCH_BITS-1:0] read_idx;
    logic [`CSR_SCRATCH_BITS-1:0] write_idx;

    // offsets wrap below the scratch base, so one compare covers the range.
    assign read_off  = read_addr - `CSR_SCRATCH0;
    assign write_off = write.addr - `CSR_SCRATCH0;
    assign read_hit  = (read_off < `CSR_ADDR_BITS'(`CSR_NUM_SCRATCH));
    assign write_hit = (write_off < `CSR_ADDR_BITS'(`CSR_NUM_SCRATCH));
    assign read_idx  = read_off[`CSR_SCRATCH_BITS-1:0];
    assign write_idx = write_off[`CSR_SCRATCH_BITS-1:0];

    always_comb begin
        read_data = '0;
        for (int i = 0; i < `CSR_NUM_THREADS; i++) begin
            if (read_hit) begin
                read_data[i] = scratch[read_wid][read_idx];
            end else begin
                case (read_addr)
                    `CSR_THREAD_ID: read_data[i] = `CSR_XLEN'(i);  // lane index.
                    `CSR_WARP_ID:   read_data[i] = `CSR_XLEN'(read_wid);
                    `CSR_CORE_ID:   read_data[i] = `CSR_XLEN'(CORE_ID);
                    default:        read_data[i] = '0;
                endcase
            end
        end
    end

    // read-only and unmapped addresses drop the write.
    always_ff @(posedge clk) begin
        if (reset) begin
            scratch <= '0;
        end else if (write_enable && write_hit) begin
            scratch[write.wid][write_idx] <= write.data[write.tid];
        end
    end

endmodule

`default_nettype wire

//--- src/csr_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "csr_macros.svh"

module csr_unit #(
    parameter int CORE_ID = 0
) (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire csr_pkg::csr_req_t          req,
    input  wire logic                       req_valid,
    output logic                            req_ready,
    output csr_pkg::csr_rsp_t               rsp,
    output logic                            rsp_valid,
    input  wire logic                       rsp_ready,
    input  wire logic [`CSR_NUM_WARPS-1:0]  gpu_pending,
    output logic      [`CSR_NUM_WARPS-1:0]  req_pending
);

    localparam int SBUF_W = $bits(csr_pkg::csr_rsp_t) + $bits(csr_pkg::csr_wr_t);

    logic [`CSR_NUM_THREADS-1:0][`CSR_XLEN-1:0] src_data;
    logic [`CSR_NUM_THREADS-1:0][`CSR_XLEN-1:0] stored_data;
    logic [`CSR_NUM_THREADS-1:0][`CSR_XLEN-1:0] old_data;
    logic [`CSR_NUM_THREADS-1:0][`CSR_XLEN-1:0] new_data;
    logic [`CSR_XLEN-1:0]                       fwd_word;
    logic [`CSR_ADDR_BITS-1:0]                  wr_off;
    logic                                       wr_scratch;
    logic                                       write_hazard;
    logic                                       write_we;
    logic                                       write_enable;
    logic                                       stall;
    logic                                       sbuf_valid_in;
    logic                                       sbuf_ready;
    csr_pkg::csr_rsp_t                          rsp_in;
    csr_pkg::csr_wr_t                           wr_in;
    csr_pkg::csr_wr_t                           wr_out;

    csr_data #(
        .CORE_ID (CORE_ID)
    ) csr_data (
        .clk          (clk),
        .reset        (reset),
        .read_wid     (req.wid),
        .read_addr    (req.addr),
        .read_data    (stored_data),
        .write        (wr_out),
        .write_enable (write_enable)
    );

    always_comb begin
        for (int i = 0; i < `CSR_NUM_THREADS; i++) begin
            src_data[i] = req.use_imm ? `CSR_XLEN'(req.imm) : req.rs1_data[i];
        end
    end

    // storage keeps only the tid lane, so forward that word to all lanes.
    assign wr_off       = wr_out.addr - `CSR_SCRATCH0;
    assign wr_scratch   = (wr_off < `CSR_ADDR_BITS'(`CSR_NUM_SCRATCH));
    assign fwd_word     = wr_out.data[wr_out.tid];
    assign write_hazard = write_enable && wr_scratch
                       && (wr_out.wid == req.wid) && (wr_out.addr == req.addr);

    always_comb begin
        for (int i = 0; i < `CSR_NUM_THREADS; i++) begin
            old_data[i] = write_hazard ? fwd_word : stored_data[i];
        end
    end

    always_comb begin
        write_we = (src_data != '0);    // set/clear only write with a nonzero source.
        for (int i = 0; i < `CSR_NUM_THREADS; i++) begin
            case (req.op)
                csr_pkg::CSR_RW: new_data[i] = src_data[i];
                csr_pkg::CSR_RS: new_data[i] = old_data[i] | src_data[i];
                default:         new_data[i] = old_data[i] & ~src_data[i];
            endcase
        end
        if (req.op == csr_pkg::CSR_RW) begin
            write_we = 1'b1;
        end
    end

    assign stall         = gpu_pending[req.wid];
    assign sbuf_valid_in = req_valid && ~stall;
    assign req_ready     = sbuf_ready && ~stall;

    always_comb begin
        rsp_in.uuid  = req.uuid;
        rsp_in.wid   = req.wid;
        rsp_in.tmask = req.tmask;
        rsp_in.pc    = req.pc;
        rsp_in.rd    = req.rd;
        rsp_in.wb    = req.wb;
        rsp_in.eop   = 1'b1;
        rsp_in.data  = old_data;

        wr_in.wid    = req.wid;
        wr_in.addr   = req.addr;
        wr_in.tid    = req.tid;
        wr_in.we     = write_we;
        wr_in.data   = new_data;
    end

    csr_skid_buffer #(
        .DATAW (SBUF_W)
    ) rsp_sbuf (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (sbuf_valid_in),
        .ready_in  (sbuf_ready),
        .data_in   ({rsp_in, wr_in}),
        .data_out  ({rsp, wr_out}),
        .valid_out (rsp_valid),
        .ready_out (rsp_ready)
    );

    // repeats with the same value while held under back-pressure.
    assign write_enable = rsp_valid && wr_out.we;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_pending <= '0;
        end else begin
            if (req_valid && req_ready) begin
                req_pending[req.wid] <= 1'b1;
            end
            if (rsp_valid && rsp_ready) begin
                req_pending[rsp.wid] <= 1'b0;   // clear wins on the same warp.
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/csr_chk.sv
`timescale 1ns/10ps
`default_nettype none

`include "csr_macros.svh"

module csr_chk (
    input wire logic                      clk,
    input wire logic                      reset,
    input wire csr_pkg::csr_req_t         req,
    input wire logic                      req_ready,
    input wire csr_pkg::csr_rsp_t         rsp,
    input wire logic                      rsp_valid,
    input wire logic                      rsp_ready,
    input wire logic [`CSR_NUM_WARPS-1:0] gpu_pending,
    input wire logic [`CSR_NUM_WARPS-1:0] req_pending
);

    // a stalled response keeps its payload.
    rsp_hold: assert property (@(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else $error("response changed while held under back-pressure");

    stall_blocks_accept: assert property (@(posedge clk) disable iff (reset)
        gpu_pending[req.wid] |-> !req_ready)
        else $error("req_ready high while the request's warp is pending");

    pending_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> req_pending == '0)
        else $error("req_pending not clear after reset");

endmodule

`default_nettype wire

//--- dv/csr_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "csr_macros.svh"

module csr_tb;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_REQS   = 3000;
    localparam int CORE_ID    = 3;

    logic                      clk;
    logic                      reset;
    csr_pkg::csr_req_t         req;
    logic                      req_valid;
    logic                      req_ready;
    csr_pkg::csr_rsp_t         rsp;
    logic                      rsp_valid;
    logic                      rsp_ready;
    logic [`CSR_NUM_WARPS-1:0] gpu_pending;
    logic [`CSR_NUM_WARPS-1:0] req_pending;

    logic [15:0]               lfsr_state;
    logic [`CSR_XLEN-1:0]      model_scr [`CSR_NUM_WARPS][`CSR_NUM_SCRATCH];
    logic [`CSR_NUM_WARPS-1:0] model_pending;
    csr_pkg::csr_rsp_t         exp_q [$];
    bit                        exp_we_q [$];
    csr_pkg::csr_req_t         dir_q [$];
    int                        occupancy;
    int                        accepted;
    int                        error_count;
    bit                        req_taken;
    logic [`CSR_NW_BITS-1:0]   last_wid;
    logic [`CSR_ADDR_BITS-1:0] last_addr;

    csr_unit #(.CORE_ID(CORE_ID)) dut (
        .clk(clk), .reset(reset), .req(req), .req_valid(req_valid), .req_ready(req_ready),
        .rsp(rsp), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready),
        .gpu_pending(gpu_pending), .req_pending(req_pending)
    );

    bind csr_unit csr_chk chk (
        .clk(clk), .reset(reset), .req(req), .req_ready(req_ready), .rsp(rsp),
        .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .gpu_pending(gpu_pending),
        .req_pending(req_pending)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic flag_mismatch(input string msg);
        error_count++;
        $display("MISMATCH at %0t ns: %s", $time, msg);
        $display("Finished with errors");
        $fatal(1, "stopped at first error");
    endtask

    task automatic abort_run(input string msg);
        error_count++;
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("Finished with errors");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);   // galois taps 16,14,13,11.
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic csr_pkg::csr_req_t make_req();
        csr_pkg::csr_req_t r;
        logic [2:0]        sel;
        logic [1:0]        opv;
        r.uuid    = '0;
        r.wid     = `CSR_NW_BITS'(rand_bits(2));
        r.tmask   = `CSR_NUM_THREADS'(rand_bits(2));
        r.pc      = rand_bits(32);
        r.rd      = `CSR_NR_BITS'(rand_bits(5));
        r.wb      = rand_bits(1) != 0;
        opv       = 2'(rand_bits(2));
        r.op      = (opv == 2'd0) ? csr_pkg::CSR_RW : csr_pkg::csr_op_e'(opv);
        r.use_imm = rand_bits(1) != 0;
        r.imm     = (rand_bits(2) == 0) ? '0 : `CSR_IMM_BITS'(rand_bits(5));
        r.tid     = `CSR_NT_BITS'(rand_bits(1));
        for (int i = 0; i < `CSR_NUM_THREADS; i++) r.rs1_data[i] = rand_bits(32);
        if (rand_bits(2) == 0) r.rs1_data = '0;     // zero source so set and clear skip the write.
        sel = 3'(rand_bits(3));
        if (sel < 3'd5 || sel == 3'd7) begin
            r.addr = `CSR_ADDR_BITS'(`CSR_SCRATCH0 + rand_bits(2));
        end else if (sel == 3'd5) begin
            r.addr = `CSR_ADDR_BITS'(`CSR_THREAD_ID + rand_bits(2));  // 0xCC3 is unmapped.
        end else begin
            r.addr = `CSR_ADDR_BITS'(rand_bits(12));
        end
        if (rand_bits(2) == 0) begin                // back-to-back hazard.
            r.wid  = last_wid;
            r.addr = last_addr;
        end
        return r;
    endfunction

    task automatic model_accept(input csr_pkg::csr_req_t r);
        csr_pkg::csr_rsp_t                          e;
        logic [`CSR_NUM_THREADS-1:0][`CSR_XLEN-1:0] src;
        logic [`CSR_NUM_THREADS-1:0][`CSR_XLEN-1:0] upd;
        bit                                         scr;
        bit                                         wr;
        scr = (r.addr >= `CSR_SCRATCH0) && (r.addr <= `CSR_SCRATCH3);
        for (int i = 0; i < `CSR_NUM_THREADS; i++) begin
            src[i] = r.use_imm ? {{(`CSR_XLEN-`CSR_IMM_BITS){1'b0}}, r.imm} : r.rs1_data[i];
            if (scr) e.data[i] = model_scr[r.wid][r.addr[1:0]];
            else if (r.addr == `CSR_THREAD_ID) e.data[i] = i;
            else if (r.addr == `CSR_WARP_ID) e.data[i] = r.wid;
            else if (r.addr == `CSR_CORE_ID) e.data[i] = CORE_ID;
            else e.data[i] = '0;
            if (r.op == csr_pkg::CSR_RW) upd[i] = src[i];
            else if (r.op == csr_pkg::CSR_RS) upd[i] = e.data[i] | src[i];
            else upd[i] = e.data[i] & ~src[i];
        end
        wr = (r.op == csr_pkg::CSR_RW) || (src != '0);
        if (scr && wr) begin
            model_scr[r.wid][r.addr[1:0]] = upd[r.tid];
        end
        e.uuid  = r.uuid;
        e.wid   = r.wid;
        e.tmask = r.tmask;
        e.pc    = r.pc;
        e.rd    = r.rd;
        e.wb    = r.wb;
        e.eop   = 1'b1;
        exp_q.push_back(e);
        exp_we_q.push_back(wr);
        last_wid  = r.wid;
        last_addr = r.addr;
    endtask

    // inputs have settled and hold until the rising edge.
    task automatic sample();
        csr_pkg::csr_rsp_t         e;
        logic [`CSR_NUM_WARPS-1:0] next_pending;
        next_pending = model_pending;
        assert (req_pending == model_pending) else
            flag_mismatch($sformatf("req_pending %b, expected %b", req_pending, model_pending));
        assert (rsp_valid == (occupancy > 0)) else
            flag_mismatch($sformatf("rsp_valid %b with %0d buffered", rsp_valid, occupancy));
        assert (req_ready == (occupancy < 2 && !gpu_pending[req.wid])) else
            flag_mismatch($sformatf("req_ready %b, buffered %0d, gpu_pending %b, warp %0d",
                                    req_ready, occupancy, gpu_pending, req.wid));
        if (rsp_valid) begin                    // write port of the entry at the output.
            assert (dut.write_enable == exp_we_q[0]) else
                flag_mismatch($sformatf("write enable %b, expected %b",
                                        dut.write_enable, exp_we_q[0]));
        end
        if (req_valid && req_ready) begin
            model_accept(req);
            next_pending[req.wid] = 1'b1;
            occupancy++;
            accepted++;
            req_taken = 1'b1;
        end
        if (rsp_valid && rsp_ready) begin
            assert (exp_q.size() > 0) else abort_run("response arrived with no request outstanding");
            e = exp_q.pop_front();
            void'(exp_we_q.pop_front());
            assert (rsp === e) else
                flag_mismatch($sformatf("uuid %0d rsp %h, expected uuid %0d rsp %h",
                                        rsp.uuid, rsp, e.uuid, e));
            next_pending[e.wid] = 1'b0;        // clear wins over a set.
            occupancy--;
        end
        model_pending = next_pending;
    endtask

    task automatic run_cycle(input bit allow_new);
        @(negedge clk);
        if (!req_valid || req_taken) begin
            req_valid = 1'b0;
            req_taken = 1'b0;
            if (dir_q.size() > 0) begin
                req       = dir_q.pop_front();
                req_valid = 1'b1;
            end else if (allow_new && rand_bits(2) != 0) begin
                req       = make_req();
                req_valid = 1'b1;
            end
            req.uuid = `CSR_UUID_BITS'(accepted);
        end
        rsp_ready = rand_bits(2) != 0;
        for (int w = 0; w < `CSR_NUM_WARPS; w++) gpu_pending[w] = rand_bits(3) == 0;
        #5;
        sample();
    endtask

    initial begin
        csr_pkg::csr_req_t rd_req;
        clk = 1'b0;
        reset = 1'b1;
        req = '0;
        req_valid = 1'b0;
        rsp_ready = 1'b0;
        gpu_pending = '0;
        lfsr_state = 16'd48874;
        model_scr = '{default: '0};
        model_pending = '0;
        occupancy = 0;
        accepted = 0;
        error_count = 0;
        req_taken = 1'b0;
        last_wid = '0;
        last_addr = `CSR_SCRATCH0;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        while (accepted < NUM_REQS) run_cycle(1'b1);
        // read back every scratch word without writing it.
        for (int w = 0; w < `CSR_NUM_WARPS; w++) begin
            for (int s = 0; s < `CSR_NUM_SCRATCH; s++) begin
                rd_req = '0;
                rd_req.wid = `CSR_NW_BITS'(w);
                rd_req.tmask = '1;
                rd_req.op = csr_pkg::CSR_RS;
                rd_req.use_imm = 1'b1;
                rd_req.addr = `CSR_ADDR_BITS'(`CSR_SCRATCH0 + s);
                dir_q.push_back(rd_req);
            end
        end
        while (dir_q.size() > 0 || (req_valid && !req_taken) || exp_q.size() > 0) begin
            run_cycle(1'b0);
        end
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(NUM_REQS * CLK_PERIOD * 8);
        $display("timeout: the run did not complete in the time allowed");
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+src
src/csr_pkg.sv
src/csr_skid_buffer.sv
src/csr_data.sv
src/csr_unit.sv
dv/csr_chk.sv
dv/csr_tb.sv

//--- Bender.yml
package:
  name: csr_unit

sources:
  - include_dirs:
      - src
    files:
      - src/csr_pkg.sv
      - src/csr_skid_buffer.sv
      - src/csr_data.sv
      - src/csr_unit.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/csr_chk.sv
      - dv/csr_tb.sv
